//--- rv_ctrl_consts.svh
// sizing constants for the pipeline control unit, included by the package and the RTL
`ifndef RV_CTRL_CONSTS_SVH
`define RV_CTRL_CONSTS_SVH

// register file address width
`define RV_REG_AW 5

// fetch, decode, execute, memory, writeback
`define RV_NSTAGE 5

// rd history entries, one per stage that can forward
`define RV_FWD_DEPTH 3

`endif

//--- rv_ctrl_pkg.sv
// shared enums and control structs for the pipeline control unit and its testbench
`default_nettype none

`include "rv_ctrl_consts.svh"

package rv_ctrl_pkg;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add, alu_sll, alu_sra, alu_sub, alu_xor, alu_srl, alu_or, alu_and
    } alu_op_e;

    // funct3 encoding of the branch compares
    typedef enum logic [2:0] {
        cmp_beq  = 3'b000,
        cmp_bne  = 3'b001,
        cmp_blt  = 3'b100,
        cmp_bge  = 3'b101,
        cmp_bltu = 3'b110,
        cmp_bgeu = 3'b111
    } cmp_op_e;

    typedef enum logic {src1_rs1, src1_pc} alu_src1_e;

    typedef enum logic [2:0] {
        src2_i_imm, src2_u_imm, src2_b_imm, src2_s_imm, src2_j_imm, src2_rs2
    } alu_src2_e;

    typedef enum logic {cmp_src_rs2, cmp_src_i_imm} cmp_src_e;

    typedef enum logic [1:0] {exe_out_alu, exe_out_u_imm, exe_out_cmp_zext} exe_out_e;

    typedef enum logic [3:0] {
        rf_alu, rf_u_imm, rf_cmp, rf_pc4, rf_lb, rf_lh, rf_lw, rf_lbu, rf_lhu
    } rf_src_e;

    typedef enum logic [1:0] {fwd_regfile, fwd_exe, fwd_mem, fwd_wb} fwd_sel_e;

    typedef enum logic [1:0] {pc_plus4, pc_alu_out, pc_alu_mod2} pc_sel_e;

    typedef struct packed {
        opcode_e               opcode;
        logic [`RV_REG_AW-1:0] rd;
        logic [`RV_REG_AW-1:0] rs1;
        logic [`RV_REG_AW-1:0] rs2;
        logic [2:0]            funct3;
        logic                  funct7_5;
    } instr_fields_t;

    typedef struct packed {
        alu_op_e   alu_op;
        alu_src1_e alu_src1;
        alu_src2_e alu_src2;
        cmp_op_e   cmp_op;
        cmp_src_e  cmp_src;
        exe_out_e  exe_out;
    } exe_ctl_t;

    typedef struct packed {
        logic       rd;
        logic       wr;
        logic [2:0] funct3;
    } mem_ctl_t;

    typedef struct packed {
        logic                  ld_reg;
        rf_src_e               rf_src;
        logic [`RV_REG_AW-1:0] rd;
    } wb_ctl_t;

    typedef struct packed {
        exe_ctl_t exe;
        mem_ctl_t mem;
        wb_ctl_t  wb;
    } ctrl_word_t;

    // bit 4 is fetch, bit 0 is writeback
    typedef struct packed {
        logic [`RV_NSTAGE-1:0] valid;
        logic [`RV_NSTAGE-1:0] ready;
    } stage_status_t;

    typedef struct packed {
        fwd_sel_e rs1_sel;
        fwd_sel_e rs2_sel;
    } fwd_t;

    typedef struct packed {
        logic ld_if_de;
        logic ld_de_exe;
        logic ld_exe_mem;
        logic ld_mem_wb;
        logic flush_if_de;
        logic flush_de_exe;
        logic flush_exe_mem;
        logic flush_mem_wb;
        logic imem_read;
        logic load_pc;
    } pipe_ctl_t;

endpackage

`default_nettype wire

//--- instr_decoder.sv
// decode stage: turns the instruction fields into the per-stage control word and use flags
`default_nettype none

module instr_decoder
    import rv_ctrl_pkg::*;
(
    input  logic          i_dec_ready,
    input  instr_fields_t i_instr,
    output ctrl_word_t    o_ctrl,
    output logic          o_use_rs1,
    output logic          o_use_rs2
);

    logic is_reg;

    // register-register ops share the immediate decode, only operand 2 differs
    assign is_reg = (i_instr.opcode == op_reg);

    always_comb begin
        // default word, also the bubble word
        o_ctrl.exe.alu_op   = alu_add;
        o_ctrl.exe.alu_src1 = src1_rs1;
        o_ctrl.exe.alu_src2 = src2_i_imm;
        o_ctrl.exe.cmp_op   = cmp_beq;
        o_ctrl.exe.cmp_src  = cmp_src_rs2;
        o_ctrl.exe.exe_out  = exe_out_alu;
        o_ctrl.mem.rd       = 1'b0;
        o_ctrl.mem.wr       = 1'b0;
        o_ctrl.mem.funct3   = 3'b000;
        o_ctrl.wb.ld_reg    = 1'b0;
        o_ctrl.wb.rf_src    = rf_alu;
        o_ctrl.wb.rd        = '0;
        o_use_rs1           = 1'b0;
        o_use_rs2           = 1'b0;

        if (i_dec_ready) begin
            case (i_instr.opcode)
                op_lui: begin
                    o_ctrl.exe.exe_out = exe_out_u_imm;
                    o_ctrl.wb.ld_reg   = 1'b1;
                    o_ctrl.wb.rf_src   = rf_u_imm;
                    o_ctrl.wb.rd       = i_instr.rd;
                end
                op_auipc: begin
                    o_ctrl.exe.alu_src1 = src1_pc;
                    o_ctrl.exe.alu_src2 = src2_u_imm;
                    o_ctrl.wb.ld_reg    = 1'b1;
                    o_ctrl.wb.rd        = i_instr.rd;
                end
                op_jal: begin
                    o_ctrl.exe.alu_src1 = src1_pc;
                    o_ctrl.exe.alu_src2 = src2_j_imm;
                    o_ctrl.wb.ld_reg    = 1'b1;
                    o_ctrl.wb.rf_src    = rf_pc4;
                    o_ctrl.wb.rd        = i_instr.rd;
                end
                op_jalr: begin
                    // target is rs1 + i_imm, low bit cleared in the PC mux
                    o_ctrl.wb.ld_reg = 1'b1;
                    o_ctrl.wb.rf_src = rf_pc4;
                    o_ctrl.wb.rd     = i_instr.rd;
                    o_use_rs1        = 1'b1;
                end
                op_br: begin
                    o_ctrl.exe.alu_src1 = src1_pc;
                    o_ctrl.exe.alu_src2 = src2_b_imm;
                    case (i_instr.funct3)
                        3'b001:  o_ctrl.exe.cmp_op = cmp_bne;
                        3'b100:  o_ctrl.exe.cmp_op = cmp_blt;
                        3'b101:  o_ctrl.exe.cmp_op = cmp_bge;
                        3'b110:  o_ctrl.exe.cmp_op = cmp_bltu;
                        3'b111:  o_ctrl.exe.cmp_op = cmp_bgeu;
                        default: o_ctrl.exe.cmp_op = cmp_beq;
                    endcase
                    o_use_rs1 = 1'b1;
                    o_use_rs2 = 1'b1;
                end
                op_load: begin
                    o_ctrl.mem.rd     = 1'b1;
                    o_ctrl.mem.funct3 = i_instr.funct3;
                    o_ctrl.wb.ld_reg  = 1'b1;
                    o_ctrl.wb.rd      = i_instr.rd;
                    case (i_instr.funct3)
                        3'b000:  o_ctrl.wb.rf_src = rf_lb;
                        3'b001:  o_ctrl.wb.rf_src = rf_lh;
                        3'b100:  o_ctrl.wb.rf_src = rf_lbu;
                        3'b101:  o_ctrl.wb.rf_src = rf_lhu;
                        default: o_ctrl.wb.rf_src = rf_lw;
                    endcase
                    o_use_rs1 = 1'b1;
                end
                op_store: begin
                    // no rd, so nothing enters the forwarding history
                    o_ctrl.exe.alu_src2 = src2_s_imm;
                    o_ctrl.mem.wr       = 1'b1;
                    o_ctrl.mem.funct3   = i_instr.funct3;
                    o_use_rs1           = 1'b1;
                    o_use_rs2           = 1'b1;
                end
                op_imm, op_reg: begin
                    o_ctrl.exe.alu_src2 = is_reg ? src2_rs2 : src2_i_imm;
                    o_ctrl.wb.ld_reg    = 1'b1;
                    o_ctrl.wb.rd        = i_instr.rd;
                    o_use_rs1           = 1'b1;
                    o_use_rs2           = is_reg;
                    case (i_instr.funct3)
                        3'b000: begin
                            // sub only exists as a register op
                            if (is_reg && i_instr.funct7_5) begin
                                o_ctrl.exe.alu_op = alu_sub;
                            end
                        end
                        3'b001:  o_ctrl.exe.alu_op = alu_sll;
                        3'b010, 3'b011: begin
                            // slt and sltu go through the comparator
                            o_ctrl.exe.cmp_op  = i_instr.funct3[0] ? cmp_bltu : cmp_blt;
                            o_ctrl.exe.cmp_src = is_reg ? cmp_src_rs2 : cmp_src_i_imm;
                            o_ctrl.exe.exe_out = exe_out_cmp_zext;
                            o_ctrl.wb.rf_src   = rf_cmp;
                        end
                        3'b100:  o_ctrl.exe.alu_op = alu_xor;
                        3'b101: begin
                            o_ctrl.exe.alu_op = i_instr.funct7_5 ? alu_sra : alu_srl;
                        end
                        3'b110:  o_ctrl.exe.alu_op = alu_or;
                        default: o_ctrl.exe.alu_op = alu_and;
                    endcase
                end
                default: begin
                end
            endcase
        end
    end

    // a load and a store never share a word
    always_comb begin
        a_mem_rd_wr_excl: assert (!(o_ctrl.mem.rd && o_ctrl.mem.wr));
    end

endmodule

`default_nettype wire

//--- fwd_unit.sv
// operand forwarding: rd history of the three older instructions and rs1/rs2 source select
`default_nettype none

`include "rv_ctrl_consts.svh"

module fwd_unit
    import rv_ctrl_pkg::*;
(
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  i_adv,
    input  ctrl_word_t            i_ctrl,
    input  logic [`RV_REG_AW-1:0] i_rs1,
    input  logic [`RV_REG_AW-1:0] i_rs2,
    input  logic                  i_use_rs1,
    input  logic                  i_use_rs2,
    output fwd_t                  o_fwd
);

    // entry 0 is the instruction now in execute, entry 2 the one in writeback
    logic [`RV_REG_AW-1:0] hist_q [`RV_FWD_DEPTH];

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 0; i < `RV_FWD_DEPTH; i++) begin
                hist_q[i] <= '0;
            end
        end else if (i_adv) begin
            hist_q[0] <= i_ctrl.wb.ld_reg ? i_ctrl.wb.rd : '0;
            for (int i = 1; i < `RV_FWD_DEPTH; i++) begin
                hist_q[i] <= hist_q[i-1];
            end
        end
    end

    // oldest match first so the nearest producer overwrites it
    function automatic fwd_sel_e pick_src(input logic [`RV_REG_AW-1:0] rs, input logic used);
        fwd_sel_e sel;
        sel = fwd_regfile;
        if (used && (rs != '0)) begin
            for (int i = `RV_FWD_DEPTH - 1; i >= 0; i--) begin
                if (hist_q[i] == rs) begin
                    sel = fwd_sel_e'(2'(i + 1));
                end
            end
        end
        return sel;
    endfunction

    always_comb begin
        o_fwd.rs1_sel = pick_src(i_rs1, i_use_rs1);
        o_fwd.rs2_sel = pick_src(i_rs2, i_use_rs2);
    end

    // x0 is hardwired, even if an older rd of 0 sits in the history
    a_x0_no_fwd: assert property (@(posedge clk) disable iff (rst)
        ((i_rs1 != '0) || (o_fwd.rs1_sel == fwd_regfile)) &&
        ((i_rs2 != '0) || (o_fwd.rs2_sel == fwd_regfile)));

endmodule

`default_nettype wire

//--- branch_redirect.sv
// execute-stage control flow: next-PC select and the registered redirect flag
`default_nettype none

module branch_redirect
    import rv_ctrl_pkg::*;
(
    input  logic    clk,
    input  logic    rst,
    input  logic    i_br_en,
    input  opcode_e i_exe_opcode,
    output pc_sel_e o_pc_sel,
    output logic    o_redirect
);

    logic br_taken;
    logic jump;
    logic redirect_q;

    assign br_taken = i_br_en && (i_exe_opcode == op_br);
    assign jump     = (i_exe_opcode == op_jal) || (i_exe_opcode == op_jalr);

    always_comb begin
        if (br_taken || (i_exe_opcode == op_jal)) begin
            o_pc_sel = pc_alu_out;
        end else if (i_exe_opcode == op_jalr) begin
            o_pc_sel = pc_alu_mod2;
        end else begin
            o_pc_sel = pc_plus4;
        end
    end

    // flush the two younger registers on the cycle after
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            redirect_q <= 1'b0;
        end else begin
            redirect_q <= br_taken || jump;
        end
    end

    assign o_redirect = redirect_q;

endmodule

`default_nettype wire

//--- pipeline_ctrl.sv
// stall and flush control: pipeline register loads and flushes, fetch request and PC load
`default_nettype none

module pipeline_ctrl
    import rv_ctrl_pkg::*;
(
    input  logic          rst,
    input  stage_status_t i_stage,
    input  logic          i_icache_resp,
    input  logic          i_redirect,
    output pipe_ctl_t     o_pipe,
    output logic          o_hist_adv
);

    logic [4:0] busy;
    logic       stall_if_de;
    logic       stall_de_exe;
    logic       stall_exe_mem;
    logic       stall_mem_wb;

    // a stage holds everything behind it while valid and not ready
    assign busy          = i_stage.valid & ~i_stage.ready;
    assign stall_if_de   = |busy[3:0];
    assign stall_de_exe  = |busy[2:0];
    assign stall_exe_mem = |busy[1:0];
    assign stall_mem_wb  = busy[0];

    always_comb begin
        o_pipe = '0;
        if (rst) begin
            o_pipe.flush_if_de   = 1'b1;
            o_pipe.flush_de_exe  = 1'b1;
            o_pipe.flush_exe_mem = 1'b1;
            o_pipe.flush_mem_wb  = 1'b1;
        end else begin
            // flush takes priority over load on the two younger registers
            o_pipe.ld_if_de   = i_icache_resp && !stall_if_de && !i_redirect;
            o_pipe.ld_de_exe  = i_icache_resp && !stall_de_exe && i_stage.valid[4]
                                && !i_redirect;
            o_pipe.ld_exe_mem = i_icache_resp && !stall_exe_mem && i_stage.valid[3];
            o_pipe.ld_mem_wb  = i_icache_resp && !stall_mem_wb && i_stage.valid[2];

            o_pipe.flush_if_de  = i_redirect;
            o_pipe.flush_de_exe = i_redirect;

            // only ask for a new fetch while no response is pending
            o_pipe.imem_read = !i_icache_resp && !stall_if_de;
            o_pipe.load_pc   = i_icache_resp && (i_redirect || !stall_if_de);
        end
    end

    // history shifts in step with the decode register
    assign o_hist_adv = o_pipe.ld_if_de;

    always_comb begin
        if (!rst) begin
            a_ld_flush_excl: assert (
                !(o_pipe.ld_if_de && o_pipe.flush_if_de) &&
                !(o_pipe.ld_de_exe && o_pipe.flush_de_exe) &&
                !(o_pipe.ld_exe_mem && o_pipe.flush_exe_mem) &&
                !(o_pipe.ld_mem_wb && o_pipe.flush_mem_wb));
        end
    end

endmodule

`default_nettype wire

//--- rv_pipe_ctrl_top.sv
// top of the RV32I pipeline control unit, connects decode, forwarding, redirect and stall logic
`default_nettype none

module rv_pipe_ctrl_top
    import rv_ctrl_pkg::*;
(
    input  logic          clk,
    input  logic          rst,
    input  instr_fields_t i_instr,
    input  logic          i_dec_ready,
    input  stage_status_t i_stage,
    input  logic          i_icache_resp,
    input  logic          i_br_en,
    input  opcode_e       i_exe_opcode,
    output ctrl_word_t    o_ctrl,
    output fwd_t          o_fwd,
    output pipe_ctl_t     o_pipe,
    output pc_sel_e       o_pc_sel
);

    logic use_rs1;
    logic use_rs2;
    logic hist_adv;
    logic redirect;

    instr_decoder u_dec (
        .i_dec_ready (i_dec_ready),
        .i_instr     (i_instr),
        .o_ctrl      (o_ctrl),
        .o_use_rs1   (use_rs1),
        .o_use_rs2   (use_rs2)
    );

    fwd_unit u_fwd (
        .clk       (clk),
        .rst       (rst),
        .i_adv     (hist_adv),
        .i_ctrl    (o_ctrl),
        .i_rs1     (i_instr.rs1),
        .i_rs2     (i_instr.rs2),
        .i_use_rs1 (use_rs1),
        .i_use_rs2 (use_rs2),
        .o_fwd     (o_fwd)
    );

    branch_redirect u_br (
        .clk          (clk),
        .rst          (rst),
        .i_br_en      (i_br_en),
        .i_exe_opcode (i_exe_opcode),
        .o_pc_sel     (o_pc_sel),
        .o_redirect   (redirect)
    );

    pipeline_ctrl u_pipe (
        .rst           (rst),
        .i_stage       (i_stage),
        .i_icache_resp (i_icache_resp),
        .i_redirect    (redirect),
        .o_pipe        (o_pipe),
        .o_hist_adv    (hist_adv)
    );

endmodule

`default_nettype wire

//--- tb_rv_pipe_ctrl.sv
// testbench for the pipeline control unit, applies a stimulus table to the top level and checks it
`default_nettype none

module tb_rv_pipe_ctrl
    import rv_ctrl_pkg::*;
();

    // expected decode fields of one row
    typedef struct packed {
        alu_op_e   alu_op;
        alu_src1_e src1;
        alu_src2_e src2;
        cmp_op_e   cmp_op;
        logic      mem_rd;
        logic      mem_wr;
        logic      ld_reg;
        rf_src_e   rf_src;
    } dec_exp_t;

    typedef struct packed {
        instr_fields_t instr;
        logic          dec_ready;
        stage_status_t stage;
        logic          resp;
        opcode_e       exe_op;
        logic          br_en;
        dec_exp_t      dec;
        fwd_sel_e      rs1_sel;
        fwd_sel_e      rs2_sel;
        pc_sel_e       pc_sel;
    } row_t;

    logic          clk = 1'b0;
    logic          rst;
    instr_fields_t instr;
    logic          dec_ready;
    stage_status_t stage;
    logic          icache_resp;
    logic          br_en;
    opcode_e       exe_opcode;
    ctrl_word_t    ctrl;
    fwd_t          fwd;
    pipe_ctl_t     pipe;
    pc_sel_e       pc_sel;

    row_t rows_q[$];

    always #20 clk = ~clk;

    rv_pipe_ctrl_top dut0 (
        .clk           (clk),
        .rst           (rst),
        .i_instr       (instr),
        .i_dec_ready   (dec_ready),
        .i_stage       (stage),
        .i_icache_resp (icache_resp),
        .i_br_en       (br_en),
        .i_exe_opcode  (exe_opcode),
        .o_ctrl        (ctrl),
        .o_fwd         (fwd),
        .o_pipe        (pipe),
        .o_pc_sel      (pc_sel)
    );

    function automatic instr_fields_t make_instr(input opcode_e op, input logic [4:0] rd,
                                                 input logic [4:0] rs1, input logic [4:0] rs2,
                                                 input logic [2:0] f3, input logic f7_5);
        instr_fields_t f;
        f.opcode   = op;
        f.rd       = rd;
        f.rs1      = rs1;
        f.rs2      = rs2;
        f.funct3   = f3;
        f.funct7_5 = f7_5;
        return f;
    endfunction

    // rw_ld packs mem read, mem write and register load
    function automatic dec_exp_t dec_exp(input alu_op_e op, input alu_src1_e s1,
                                         input alu_src2_e s2, input cmp_op_e cmp,
                                         input logic [2:0] rw_ld, input rf_src_e rf);
        dec_exp_t d;
        d.alu_op = op;
        d.src1   = s1;
        d.src2   = s2;
        d.cmp_op = cmp;
        {d.mem_rd, d.mem_wr, d.ld_reg} = rw_ld;
        d.rf_src = rf;
        return d;
    endfunction

    // reference stall chain: a register waits on every stage behind it
    function automatic pipe_ctl_t model_pipe(input stage_status_t st, input logic resp,
                                             input logic redir);
        pipe_ctl_t  p;
        logic [4:0] busy;
        busy = st.valid & ~st.ready;
        p = '0;
        p.ld_if_de     = resp && (busy[3:0] == 4'd0) && !redir;
        p.ld_de_exe    = resp && (busy[2:0] == 3'd0) && st.valid[4] && !redir;
        p.ld_exe_mem   = resp && (busy[1:0] == 2'd0) && st.valid[3];
        p.ld_mem_wb    = resp && !busy[0] && st.valid[2];
        p.flush_if_de  = redir;
        p.flush_de_exe = redir;
        p.imem_read    = !resp && (busy[3:0] == 4'd0);
        p.load_pc      = resp && (redir || (busy[3:0] == 4'd0));
        return p;
    endfunction

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "stopping at the first error");
    endtask

    task automatic compare(input string what, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            abort_run($sformatf("ERR %0t: %s got %0h expected %0h", $time, what, got, exp));
        end
    endtask

    task automatic add_row(input instr_fields_t ins, input logic rdy, input logic resp,
                           input opcode_e xop, input logic br, input dec_exp_t d,
                           input fwd_sel_e f1, input fwd_sel_e f2, input pc_sel_e pc,
                           input stage_status_t st);
        row_t r;
        r.instr     = ins;
        r.dec_ready = rdy;
        r.stage     = st;
        r.resp      = resp;
        r.exe_op    = xop;
        r.br_en     = br;
        r.dec       = d;
        r.rs1_sel   = f1;
        r.rs2_sel   = f2;
        r.pc_sel    = pc;
        rows_q.push_back(r);
    endtask

    // no response, so the history holds still
    task automatic dec_row(input instr_fields_t ins, input dec_exp_t d);
        add_row(ins, 1'b1, 1'b0, op_imm, 1'b0, d, fwd_regfile, fwd_regfile, pc_plus4,
                {5'h1f, 5'h1f});
    endtask

    task automatic fwd_row(input instr_fields_t ins, input logic resp, input dec_exp_t d,
                           input fwd_sel_e f1, input fwd_sel_e f2);
        add_row(ins, 1'b1, resp, op_imm, 1'b0, d, f1, f2, pc_plus4, {5'h1f, 5'h1f});
    endtask

    task automatic br_row(input logic resp, input opcode_e xop, input logic br,
                          input pc_sel_e pc);
        dec_exp_t bubble;
        bubble = dec_exp(alu_add, src1_rs1, src2_i_imm, cmp_beq, 3'b000, rf_alu);
        add_row(make_instr(op_imm, 5'd0, 5'd0, 5'd0, 3'd0, 1'b0), 1'b0, resp, xop, br, bubble,
                fwd_regfile, fwd_regfile, pc, {5'h1f, 5'h1f});
    endtask

    task automatic build_table();
        dec_exp_t      d_addi;
        dec_exp_t      d_add;
        dec_exp_t      d_store;
        dec_exp_t      d_lui;
        dec_exp_t      d_bubble;
        stage_status_t st;
        d_addi   = dec_exp(alu_add, src1_rs1, src2_i_imm, cmp_beq, 3'b001, rf_alu);
        d_add    = dec_exp(alu_add, src1_rs1, src2_rs2, cmp_beq, 3'b001, rf_alu);
        d_store  = dec_exp(alu_add, src1_rs1, src2_s_imm, cmp_beq, 3'b010, rf_alu);
        d_lui    = dec_exp(alu_add, src1_rs1, src2_i_imm, cmp_beq, 3'b001, rf_u_imm);
        d_bubble = dec_exp(alu_add, src1_rs1, src2_i_imm, cmp_beq, 3'b000, rf_alu);

        // decode, one row per opcode and funct3 class
        dec_row(make_instr(op_lui, 5'd3, 5'd1, 5'd2, 3'd0, 1'b0), d_lui);
        dec_row(make_instr(op_auipc, 5'd3, 5'd1, 5'd2, 3'd0, 1'b0),
                dec_exp(alu_add, src1_pc, src2_u_imm, cmp_beq, 3'b001, rf_alu));
        dec_row(make_instr(op_jal, 5'd3, 5'd1, 5'd2, 3'd0, 1'b0),
                dec_exp(alu_add, src1_pc, src2_j_imm, cmp_beq, 3'b001, rf_pc4));
        dec_row(make_instr(op_jalr, 5'd3, 5'd1, 5'd2, 3'd0, 1'b0),
                dec_exp(alu_add, src1_rs1, src2_i_imm, cmp_beq, 3'b001, rf_pc4));
        dec_row(make_instr(op_br, 5'd3, 5'd1, 5'd2, 3'd5, 1'b0),
                dec_exp(alu_add, src1_pc, src2_b_imm, cmp_bge, 3'b000, rf_alu));
        dec_row(make_instr(op_br, 5'd3, 5'd1, 5'd2, 3'd6, 1'b0),
                dec_exp(alu_add, src1_pc, src2_b_imm, cmp_bltu, 3'b000, rf_alu));
        dec_row(make_instr(op_load, 5'd3, 5'd1, 5'd2, 3'd4, 1'b0),
                dec_exp(alu_add, src1_rs1, src2_i_imm, cmp_beq, 3'b101, rf_lbu));
        dec_row(make_instr(op_load, 5'd3, 5'd1, 5'd2, 3'd2, 1'b0),
                dec_exp(alu_add, src1_rs1, src2_i_imm, cmp_beq, 3'b101, rf_lw));
        dec_row(make_instr(op_store, 5'd3, 5'd1, 5'd2, 3'd2, 1'b0), d_store);
        // funct7 bit 5 set on an immediate op is still an add
        dec_row(make_instr(op_imm, 5'd3, 5'd1, 5'd2, 3'd0, 1'b1), d_addi);
        dec_row(make_instr(op_reg, 5'd3, 5'd1, 5'd2, 3'd0, 1'b1),
                dec_exp(alu_sub, src1_rs1, src2_rs2, cmp_beq, 3'b001, rf_alu));
        dec_row(make_instr(op_reg, 5'd3, 5'd1, 5'd2, 3'd5, 1'b1),
                dec_exp(alu_sra, src1_rs1, src2_rs2, cmp_beq, 3'b001, rf_alu));
        dec_row(make_instr(op_imm, 5'd3, 5'd1, 5'd2, 3'd5, 1'b0),
                dec_exp(alu_srl, src1_rs1, src2_i_imm, cmp_beq, 3'b001, rf_alu));
        dec_row(make_instr(op_imm, 5'd3, 5'd1, 5'd2, 3'd3, 1'b0),
                dec_exp(alu_add, src1_rs1, src2_i_imm, cmp_bltu, 3'b001, rf_cmp));
        dec_row(make_instr(op_reg, 5'd3, 5'd1, 5'd2, 3'd2, 1'b0),
                dec_exp(alu_add, src1_rs1, src2_rs2, cmp_blt, 3'b001, rf_cmp));
        dec_row(make_instr(op_reg, 5'd3, 5'd1, 5'd2, 3'd7, 1'b0),
                dec_exp(alu_and, src1_rs1, src2_rs2, cmp_beq, 3'b001, rf_alu));
        dec_row(make_instr(op_reg, 5'd3, 5'd1, 5'd2, 3'd6, 1'b0),
                dec_exp(alu_or, src1_rs1, src2_rs2, cmp_beq, 3'b001, rf_alu));
        dec_row(make_instr(op_reg, 5'd3, 5'd1, 5'd2, 3'd4, 1'b0),
                dec_exp(alu_xor, src1_rs1, src2_rs2, cmp_beq, 3'b001, rf_alu));
        dec_row(make_instr(op_imm, 5'd3, 5'd1, 5'd2, 3'd1, 1'b0),
                dec_exp(alu_sll, src1_rs1, src2_i_imm, cmp_beq, 3'b001, rf_alu));
        add_row(make_instr(op_reg, 5'd3, 5'd1, 5'd2, 3'd0, 1'b1), 1'b0, 1'b0, op_imm, 1'b0,
                d_bubble, fwd_regfile, fwd_regfile, pc_plus4, {5'h1f, 5'h1f});

        // forwarding, history shown nearest first after each advance
        fwd_row(make_instr(op_imm, 5'd5, 5'd1, 5'd0, 3'd0, 1'b0), 1'b1, d_addi,
                fwd_regfile, fwd_regfile);
        fwd_row(make_instr(op_imm, 5'd6, 5'd5, 5'd0, 3'd0, 1'b0), 1'b1, d_addi,
                fwd_exe, fwd_regfile);
        // 7 6 5 after this one
        fwd_row(make_instr(op_imm, 5'd7, 5'd5, 5'd0, 3'd0, 1'b0), 1'b1, d_addi,
                fwd_mem, fwd_regfile);
        fwd_row(make_instr(op_reg, 5'd8, 5'd7, 5'd6, 3'd0, 1'b0), 1'b0, d_add, fwd_exe, fwd_mem);
        fwd_row(make_instr(op_reg, 5'd8, 5'd5, 5'd0, 3'd0, 1'b0), 1'b0, d_add, fwd_wb, fwd_regfile);
        fwd_row(make_instr(op_reg, 5'd8, 5'd9, 5'd5, 3'd0, 1'b0), 1'b0, d_add, fwd_regfile, fwd_wb);
        fwd_row(make_instr(op_imm, 5'd8, 5'd7, 5'd7, 3'd0, 1'b0), 1'b0, d_addi,
                fwd_exe, fwd_regfile);
        // store shifts in 0, not its immediate bits
        fwd_row(make_instr(op_store, 5'd12, 5'd6, 5'd7, 3'd2, 1'b0), 1'b1, d_store,
                fwd_mem, fwd_exe);
        fwd_row(make_instr(op_reg, 5'd10, 5'd7, 5'd6, 3'd0, 1'b0), 1'b1, d_add, fwd_mem, fwd_wb);
        fwd_row(make_instr(op_reg, 5'd8, 5'd0, 5'd7, 3'd0, 1'b0), 1'b0, d_add, fwd_regfile, fwd_wb);
        fwd_row(make_instr(op_reg, 5'd8, 5'd12, 5'd10, 3'd0, 1'b0), 1'b0, d_add,
                fwd_regfile, fwd_exe);
        fwd_row(make_instr(op_lui, 5'd4, 5'd10, 5'd10, 3'd0, 1'b0), 1'b0, d_lui,
                fwd_regfile, fwd_regfile);

        // redirect, flushes show up one row later
        br_row(1'b1, op_br, 1'b1, pc_alu_out);
        br_row(1'b1, op_imm, 1'b0, pc_plus4);
        br_row(1'b1, op_jalr, 1'b0, pc_alu_mod2);
        br_row(1'b1, op_imm, 1'b0, pc_plus4);
        br_row(1'b1, op_br, 1'b0, pc_plus4);
        br_row(1'b1, op_imm, 1'b0, pc_plus4);
        br_row(1'b1, op_jal, 1'b0, pc_alu_out);
        br_row(1'b0, op_br, 1'b1, pc_alu_out);
        br_row(1'b0, op_imm, 1'b1, pc_plus4);
        br_row(1'b1, op_imm, 1'b0, pc_plus4);

        // random stage vectors, ready biased high so loads do happen
        for (int i = 0; i < 24; i++) begin
            st.valid = 5'($urandom);
            st.ready = 5'($urandom) | 5'($urandom);
            add_row(make_instr(op_imm, 5'd0, 5'd0, 5'd0, 3'd0, 1'b0), 1'b0, 1'($urandom),
                    op_imm, 1'b0, d_bubble, fwd_regfile, fwd_regfile, pc_plus4, st);
        end
    endtask

    task automatic check_row(input row_t r, input logic redir);
        logic [4:0] rd_exp;
        logic [2:0] f3_exp;
        exe_out_e   out_exp;
        cmp_src_e   csrc_exp;
        rd_exp = r.dec.ld_reg ? r.instr.rd : 5'd0;
        f3_exp = (r.dec.mem_rd || r.dec.mem_wr) ? r.instr.funct3 : 3'd0;
        // u immediate and compare results leave execute without the ALU
        case (r.dec.rf_src)
            rf_u_imm: out_exp = exe_out_u_imm;
            rf_cmp:   out_exp = exe_out_cmp_zext;
            default:  out_exp = exe_out_alu;
        endcase
        // only slti and sltiu compare against the immediate
        if ((r.dec.rf_src == rf_cmp) && (r.dec.src2 == src2_i_imm)) begin
            csrc_exp = cmp_src_i_imm;
        end else begin
            csrc_exp = cmp_src_rs2;
        end
        compare("alu_op", 32'(ctrl.exe.alu_op), 32'(r.dec.alu_op));
        compare("alu_src1", 32'(ctrl.exe.alu_src1), 32'(r.dec.src1));
        compare("alu_src2", 32'(ctrl.exe.alu_src2), 32'(r.dec.src2));
        compare("cmp_op", 32'(ctrl.exe.cmp_op), 32'(r.dec.cmp_op));
        compare("cmp_src", 32'(ctrl.exe.cmp_src), 32'(csrc_exp));
        compare("exe_out", 32'(ctrl.exe.exe_out), 32'(out_exp));
        compare("mem read", 32'(ctrl.mem.rd), 32'(r.dec.mem_rd));
        compare("mem write", 32'(ctrl.mem.wr), 32'(r.dec.mem_wr));
        compare("mem funct3", 32'(ctrl.mem.funct3), 32'(f3_exp));
        compare("ld_reg", 32'(ctrl.wb.ld_reg), 32'(r.dec.ld_reg));
        compare("rf_src", 32'(ctrl.wb.rf_src), 32'(r.dec.rf_src));
        compare("wb rd", 32'(ctrl.wb.rd), 32'(rd_exp));
        compare("rs1 fwd", 32'(fwd.rs1_sel), 32'(r.rs1_sel));
        compare("rs2 fwd", 32'(fwd.rs2_sel), 32'(r.rs2_sel));
        compare("pc_sel", 32'(pc_sel), 32'(r.pc_sel));
        compare("pipe ctl", 32'(pipe), 32'(model_pipe(r.stage, r.resp, redir)));
    endtask

    initial begin
        row_t      r;
        pipe_ctl_t rst_pipe;
        logic      redir_exp;

        void'($urandom(3));
        rst         = 1'b1;
        instr       = make_instr(op_imm, 5'd0, 5'd0, 5'd0, 3'd0, 1'b0);
        dec_ready   = 1'b0;
        stage       = {5'h1f, 5'h1f};
        icache_resp = 1'b1;
        br_en       = 1'b0;
        exe_opcode  = op_imm;
        build_table();

        // everything would load if reset did not hold it
        rst_pipe               = '0;
        rst_pipe.flush_if_de   = 1'b1;
        rst_pipe.flush_de_exe  = 1'b1;
        rst_pipe.flush_exe_mem = 1'b1;
        rst_pipe.flush_mem_wb  = 1'b1;
        repeat (3) begin
            @(posedge clk);
            @(negedge clk);
            compare("pipe ctl in reset", 32'(pipe), 32'(rst_pipe));
        end
        @(posedge clk);
        rst         <= 1'b0;
        icache_resp <= 1'b0;
        // redirect is clear straight out of reset, so no flush remains
        @(negedge clk);
        compare("pipe ctl after reset", 32'(pipe), 32'(model_pipe(stage, 1'b0, 1'b0)));

        redir_exp = 1'b0;
        for (int i = 0; i < rows_q.size(); i++) begin
            r = rows_q[i];
            @(posedge clk);
            instr       <= r.instr;
            dec_ready   <= r.dec_ready;
            stage       <= r.stage;
            icache_resp <= r.resp;
            exe_opcode  <= r.exe_op;
            br_en       <= r.br_en;
            @(negedge clk);
            check_row(r, redir_exp);
            redir_exp = ((r.exe_op == op_br) && r.br_en) || (r.exe_op == op_jal)
                        || (r.exe_op == op_jalr);
        end

        $display("** PASS **");
        $finish;
    end

endmodule

`default_nettype wire

//--- tb.f
+incdir+.
rv_ctrl_pkg.sv
instr_decoder.sv
fwd_unit.sv
branch_redirect.sv
pipeline_ctrl.sv
rv_pipe_ctrl_top.sv
tb_rv_pipe_ctrl.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert --top-module tb_rv_pipe_ctrl -f tb.f -o tb_sim &&
./obj_dir/tb_sim | tee /dev/stderr | grep -qF -- '** PASS **' &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
